// File: logic/snitch_pkg.sv
/* Widths, opcodes, control encodings and shared records for the RV32I core.
   Compiled first and imported by every RTL module of the core. */
package snitch_pkg;

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // --------------------------------------------------
  // Major opcodes
  // --------------------------------------------------
  localparam logic [6:0] OpcodeOp     = 7'b0110011;
  localparam logic [6:0] OpcodeOpImm  = 7'b0010011;
  localparam logic [6:0] OpcodeLui    = 7'b0110111;
  localparam logic [6:0] OpcodeAuipc  = 7'b0010111;
  localparam logic [6:0] OpcodeJal    = 7'b1101111;
  localparam logic [6:0] OpcodeJalr   = 7'b1100111;
  localparam logic [6:0] OpcodeBranch = 7'b1100011;

  // --------------------------------------------------
  // Control encodings
  // --------------------------------------------------
  typedef enum logic [3:0] {
    Add, Sub,
    Sll, Srl, Sra,
    LXor, LOr, LAnd,
    Eq, Neq, Slt, Sltu, Ge, Geu,
    BypassA
  } alu_op_e;

  typedef enum logic [1:0] {OpaNone, OpaReg, OpaUImm, OpaJImm} opa_sel_e;
  typedef enum logic [1:0] {OpbNone, OpbReg, OpbIImm, OpbPc} opb_sel_e;

  // Exception vectors to the trap address
  typedef enum logic [1:0] {Consec, Alu, Exception} next_pc_e;

  typedef enum logic [1:0] {RdAlu, RdConsecPc, RdBypass} rd_sel_e;

  // Everything execute and fetch need from one instruction word
  typedef struct packed {
    alu_op_e    alu_op;
    opa_sel_e   opa_sel;
    opb_sel_e   opb_sel;
    next_pc_e   next_pc;
    rd_sel_e    rd_sel;
    logic       write_rd;
    logic       is_branch;
    logic       zero_lsb;
    logic       illegal;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    word_t      iimm;
    word_t      uimm;
    word_t      jimm;
    word_t      bimm;
  } decoded_t;

  // One record per retired instruction
  typedef struct packed {
    logic       valid;
    logic       trap;
    word_t      pc;
    word_t      insn;
    logic [4:0] rd;
    word_t      wdata;
  } retire_t;

endpackage

// File: logic/snitch_fetch.sv
/* Program counter and instruction fetch handshake.
   Advances the PC once per accepted instruction word. */
`timescale 1ns/1ps

module snitch_fetch import snitch_pkg::*; #(
  parameter word_t BootAddr  = 32'h0000_1000,
  parameter word_t MtvecAddr = 32'h0000_1000
) (
  input  logic     clk_i,
  input  logic     reset_i,
  output word_t    inst_addr_o,
  output logic     inst_valid_o,
  input  logic     inst_ready_i,
  input  next_pc_e next_pc_i,
  input  logic     zero_lsb_i,
  input  word_t    jump_target_i,
  input  word_t    consec_pc_i,
  output word_t    pc_o,
  output logic     accept_o
);

  word_t pc_d, pc_q;
  logic  valid_q;

  assign inst_addr_o  = pc_q;
  assign inst_valid_o = valid_q;
  assign pc_o         = pc_q;
  assign accept_o     = valid_q & inst_ready_i;

  // PC only moves when the word was taken
  always_comb begin
    pc_d = pc_q;
    if (accept_o) begin
      unique case (next_pc_i)
        Consec:    pc_d = consec_pc_i;
        Alu:       pc_d = jump_target_i & ~{{(XLEN-1){1'b0}}, zero_lsb_i};
        Exception: pc_d = MtvecAddr;
        default:   pc_d = MtvecAddr;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q    <= BootAddr;
      valid_q <= 1'b0;
    end else begin
      pc_q    <= pc_d;
      valid_q <= 1'b1;
    end
  end

endmodule

// File: logic/snitch_decoder.sv
/* RV32I decoder for the integer subset of the core.
   Turns the fetched word into control fields, immediates and register indices. */
`timescale 1ns/1ps

module snitch_decoder import snitch_pkg::*; #(
  parameter int unsigned RegAddrWidth = 5
) (
  input  word_t                   inst_data_i,
  output decoded_t                decoded_o,
  output logic [RegAddrWidth-1:0] raddr_a_o,
  output logic [RegAddrWidth-1:0] raddr_b_o
);

  localparam int unsigned NumRegs = 2**RegAddrWidth;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst_data_i[6:0];
  assign funct3 = inst_data_i[14:12];
  assign funct7 = inst_data_i[31:25];

  assign raddr_a_o = inst_data_i[15 +: RegAddrWidth];
  assign raddr_b_o = inst_data_i[20 +: RegAddrWidth];

  // Shared funct3 map of OP and OP-IMM where alt picks SUB or SRA
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    unique case (f3)
      3'b000:  op = alt ? Sub : Add;
      3'b001:  op = Sll;
      3'b010:  op = Slt;
      3'b011:  op = Sltu;
      3'b100:  op = LXor;
      3'b101:  op = alt ? Sra : Srl;
      3'b110:  op = LOr;
      default: op = LAnd;
    endcase
    return op;
  endfunction

  always_comb begin
    decoded_o           = '0;
    decoded_o.alu_op    = Add;
    decoded_o.opa_sel   = OpaNone;
    decoded_o.opb_sel   = OpbNone;
    decoded_o.next_pc   = Consec;
    decoded_o.rd_sel    = RdAlu;
    decoded_o.write_rd  = 1'b1;
    decoded_o.rd        = inst_data_i[11:7];
    decoded_o.rs1       = inst_data_i[19:15];
    decoded_o.rs2       = inst_data_i[24:20];

    // Sign-extended immediates
    decoded_o.iimm = {{20{inst_data_i[31]}}, inst_data_i[31:20]};
    decoded_o.uimm = {inst_data_i[31:12], 12'b0};
    decoded_o.jimm = {{12{inst_data_i[31]}}, inst_data_i[19:12], inst_data_i[20],
                      inst_data_i[30:21], 1'b0};
    decoded_o.bimm = {{20{inst_data_i[31]}}, inst_data_i[7], inst_data_i[30:25],
                      inst_data_i[11:8], 1'b0};

    unique case (opcode)
      OpcodeOp: begin
        decoded_o.opa_sel = OpaReg;
        decoded_o.opb_sel = OpbReg;
        decoded_o.alu_op  = arith_op(funct3, funct7[5]);
        // funct7 alternate only for SUB and SRA
        if (!(funct7 == 7'b0000000 ||
              (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          decoded_o.illegal = 1'b1;
        end
      end
      OpcodeOpImm: begin
        decoded_o.opa_sel = OpaReg;
        decoded_o.opb_sel = OpbIImm;
        decoded_o.alu_op  = arith_op(funct3, (funct3 == 3'b101) & funct7[5]);
        if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
          decoded_o.illegal = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000) begin
          decoded_o.illegal = 1'b1;
        end
      end
      OpcodeLui: begin
        decoded_o.alu_op  = BypassA;
        decoded_o.opa_sel = OpaUImm;
      end
      OpcodeAuipc: begin
        decoded_o.opa_sel = OpaUImm;
        decoded_o.opb_sel = OpbPc;
      end
      OpcodeJal: begin
        decoded_o.opa_sel = OpaJImm;
        decoded_o.opb_sel = OpbPc;
        decoded_o.next_pc = Alu;
        decoded_o.rd_sel  = RdConsecPc;
      end
      OpcodeJalr: begin
        decoded_o.opa_sel  = OpaReg;
        decoded_o.opb_sel  = OpbIImm;
        decoded_o.next_pc  = Alu;
        decoded_o.rd_sel   = RdConsecPc;
        decoded_o.zero_lsb = 1'b1;
        decoded_o.illegal  = (funct3 != 3'b000);
      end
      OpcodeBranch: begin
        decoded_o.opa_sel   = OpaReg;
        decoded_o.opb_sel   = OpbReg;
        decoded_o.is_branch = 1'b1;
        decoded_o.write_rd  = 1'b0;
        unique case (funct3)
          3'b000:  decoded_o.alu_op = Eq;
          3'b001:  decoded_o.alu_op = Neq;
          3'b100:  decoded_o.alu_op = Slt;
          3'b101:  decoded_o.alu_op = Ge;
          3'b110:  decoded_o.alu_op = Sltu;
          3'b111:  decoded_o.alu_op = Geu;
          default: decoded_o.illegal = 1'b1;
        endcase
      end
      default: decoded_o.illegal = 1'b1;
    endcase

    // Reduced register file rejects indices it does not hold
    if ((decoded_o.write_rd && int'(decoded_o.rd) >= NumRegs) ||
        (decoded_o.opa_sel == OpaReg && int'(decoded_o.rs1) >= NumRegs) ||
        (decoded_o.opb_sel == OpbReg && int'(decoded_o.rs2) >= NumRegs)) begin
      decoded_o.illegal = 1'b1;
    end

    // Illegal word leaves no trace except the trap jump
    if (decoded_o.illegal) begin
      decoded_o.write_rd = 1'b0;
      decoded_o.next_pc  = Exception;
    end
  end

endmodule

// File: logic/snitch_regfile.sv
/* Integer register file, two combinational reads and one write per cycle.
   Register zero reads as zero and ignores writes. */
`timescale 1ns/1ps

module snitch_regfile import snitch_pkg::*; #(
  parameter int unsigned RegAddrWidth = 5
) (
  input  logic                    clk_i,
  input  logic [RegAddrWidth-1:0] raddr_a_i,
  input  logic [RegAddrWidth-1:0] raddr_b_i,
  output word_t                   rdata_a_o,
  output word_t                   rdata_b_o,
  input  logic                    we_i,
  input  logic [RegAddrWidth-1:0] waddr_i,
  input  word_t                   wdata_i
);

  localparam int unsigned NumRegs = 2**RegAddrWidth;

  // Entry zero is not stored at all
  word_t regs_q [1:NumRegs-1];

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  always_ff @(posedge clk_i) begin
    if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

// File: logic/snitch_execute.sv
/* Execute and write-back stage with the shared adder/shifter ALU.
   Also forms the branch PC and registers the retire record. */
`timescale 1ns/1ps

module snitch_execute import snitch_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       accept_i,
  input  word_t      pc_i,
  input  word_t      insn_i,
  input  decoded_t   decoded_i,
  input  word_t      rdata_a_i,
  input  word_t      rdata_b_i,
  output logic       we_o,
  output logic [4:0] waddr_o,
  output word_t      wdata_o,
  output word_t      jump_target_o,
  output word_t      consec_pc_o,
  output retire_t    retire_o
);

  word_t       opa, opb;
  word_t       alu_result;
  word_t       consec_pc;
  logic [32:0] alu_opa, alu_opb, adder_result;
  logic        adder_sub, cmp_unsigned;
  logic        shift_left, shift_arith;
  word_t       opa_reversed, shift_operand;
  word_t       shift_right_result, shift_left_result;
  logic [32:0] shift_operand_ext, shift_result_ext;
  logic        rd_written;
  retire_t     retire_q;

  // --------------------------------------------------
  // Operand select
  // --------------------------------------------------
  always_comb begin
    unique case (decoded_i.opa_sel)
      OpaNone: opa = '0;
      OpaReg:  opa = rdata_a_i;
      OpaUImm: opa = decoded_i.uimm;
      OpaJImm: opa = decoded_i.jimm;
    endcase
    unique case (decoded_i.opb_sel)
      OpbNone: opb = '0;
      OpbReg:  opb = rdata_b_i;
      OpbIImm: opb = decoded_i.iimm;
      OpbPc:   opb = pc_i;
    endcase
  end

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  assign adder_sub    = decoded_i.alu_op inside {Sub, Eq, Neq, Slt, Sltu, Ge, Geu};
  assign cmp_unsigned = decoded_i.alu_op inside {Sltu, Geu};
  assign shift_left   = (decoded_i.alu_op == Sll);
  assign shift_arith  = (decoded_i.alu_op == Sra);

  // Bit 32 carries the sign for compares
  assign alu_opa      = {~cmp_unsigned & opa[XLEN-1], opa};
  assign alu_opb      = {~cmp_unsigned & opb[XLEN-1], opb} ^ {33{adder_sub}};
  assign adder_result = alu_opa + alu_opb + {32'b0, adder_sub};

  // Left shift is a right shift of the reversed operand
  for (genvar i = 0; i < XLEN; i++) begin : gen_reverse
    assign opa_reversed[i]      = opa[XLEN-1-i];
    assign shift_left_result[i] = shift_right_result[XLEN-1-i];
  end
  assign shift_operand      = shift_left ? opa_reversed : opa;
  assign shift_operand_ext  = {shift_arith & shift_operand[XLEN-1], shift_operand};
  assign shift_result_ext   = $unsigned($signed(shift_operand_ext) >>> opb[4:0]);
  assign shift_right_result = shift_result_ext[XLEN-1:0];

  always_comb begin
    unique case (decoded_i.alu_op)
      Add, Sub:   alu_result = adder_result[XLEN-1:0];
      Sll:        alu_result = shift_left_result;
      Srl, Sra:   alu_result = shift_right_result;
      LXor:       alu_result = opa ^ opb;
      LOr:        alu_result = opa | opb;
      LAnd:       alu_result = opa & opb;
      Eq:         alu_result = {31'b0, ~|adder_result[XLEN-1:0]};
      Neq:        alu_result = {31'b0, |adder_result[XLEN-1:0]};
      Slt, Sltu:  alu_result = {31'b0, adder_result[32]};
      Ge, Geu:    alu_result = {31'b0, ~adder_result[32]};
      BypassA:    alu_result = opa;
      default:    alu_result = adder_result[XLEN-1:0];
    endcase
  end

  // --------------------------------------------------
  // Next PC and write-back
  // --------------------------------------------------
  assign consec_pc = pc_i + ((decoded_i.is_branch & alu_result[0]) ? decoded_i.bimm : 32'd4);

  assign jump_target_o = alu_result;
  assign consec_pc_o   = consec_pc;

  always_comb begin
    unique case (decoded_i.rd_sel)
      RdAlu:      wdata_o = alu_result;
      RdConsecPc: wdata_o = consec_pc;
      default:    wdata_o = alu_result;
    endcase
  end

  assign rd_written = decoded_i.write_rd & (decoded_i.rd != 5'd0);
  assign we_o       = accept_i & rd_written;
  assign waddr_o    = decoded_i.rd;

  // Retire record one cycle behind the accept
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retire_q.valid <= 1'b0;
    end else begin
      retire_q.valid <= accept_i;
      if (accept_i) begin
        retire_q.trap  <= decoded_i.illegal;
        retire_q.pc    <= pc_i;
        retire_q.insn  <= insn_i;
        retire_q.rd    <= rd_written ? decoded_i.rd : 5'd0;
        retire_q.wdata <= rd_written ? wdata_o : '0;
      end
    end
  end

  assign retire_o = retire_q;

endmodule

// File: logic/snitch_core.sv
/* Top level of the single-issue RV32I core.
   Ties fetch, decode, register file and execute together. */
`timescale 1ns/1ps

module snitch_core import snitch_pkg::*; #(
  parameter word_t       BootAddr     = 32'h0000_1000,
  parameter word_t       MtvecAddr    = 32'h0000_0100,
  parameter int unsigned RegAddrWidth = 5
) (
  input  logic    clk_i,
  input  logic    reset_i,
  output word_t   inst_addr_o,
  input  word_t   inst_data_i,
  output logic    inst_valid_o,
  input  logic    inst_ready_i,
  output retire_t retire_o
);

  word_t                   pc;
  logic                    accept;
  decoded_t                decoded;
  logic [RegAddrWidth-1:0] raddr_a, raddr_b;
  word_t                   rdata_a, rdata_b;
  logic                    we;
  logic [4:0]              waddr;
  word_t                   wdata;
  word_t                   jump_target, consec_pc;

  snitch_fetch #(
    .BootAddr  ( BootAddr  ),
    .MtvecAddr ( MtvecAddr )
  ) i_snitch_fetch (
    .clk_i         ( clk_i            ),
    .reset_i       ( reset_i          ),
    .inst_addr_o   ( inst_addr_o      ),
    .inst_valid_o  ( inst_valid_o     ),
    .inst_ready_i  ( inst_ready_i     ),
    .next_pc_i     ( decoded.next_pc  ),
    .zero_lsb_i    ( decoded.zero_lsb ),
    .jump_target_i ( jump_target      ),
    .consec_pc_i   ( consec_pc        ),
    .pc_o          ( pc               ),
    .accept_o      ( accept           )
  );

  snitch_decoder #(
    .RegAddrWidth ( RegAddrWidth )
  ) i_snitch_decoder (
    .inst_data_i ( inst_data_i ),
    .decoded_o   ( decoded     ),
    .raddr_a_o   ( raddr_a     ),
    .raddr_b_o   ( raddr_b     )
  );

  // Legal writes always fit the configured index width
  snitch_regfile #(
    .RegAddrWidth ( RegAddrWidth )
  ) i_snitch_regfile (
    .clk_i     ( clk_i                     ),
    .raddr_a_i ( raddr_a                   ),
    .raddr_b_i ( raddr_b                   ),
    .rdata_a_o ( rdata_a                   ),
    .rdata_b_o ( rdata_b                   ),
    .we_i      ( we                        ),
    .waddr_i   ( waddr[RegAddrWidth-1:0]   ),
    .wdata_i   ( wdata                     )
  );

  snitch_execute i_snitch_execute (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .accept_i      ( accept      ),
    .pc_i          ( pc          ),
    .insn_i        ( inst_data_i ),
    .decoded_i     ( decoded     ),
    .rdata_a_i     ( rdata_a     ),
    .rdata_b_i     ( rdata_b     ),
    .we_o          ( we          ),
    .waddr_o       ( waddr       ),
    .wdata_o       ( wdata       ),
    .jump_target_o ( jump_target ),
    .consec_pc_o   ( consec_pc   ),
    .retire_o      ( retire_o    )
  );

endmodule

// File: verification/snitch_core_sva.sv
/* Concurrent checks on the fetch handshake and the retire port.
   Bound into the core from the testbench. */
`timescale 1ns/1ps

module snitch_core_sva import snitch_pkg::*; (
  input logic    clk_i,
  input logic    reset_i,
  input word_t   inst_addr_o,
  input logic    inst_valid_o,
  input logic    inst_ready_i,
  input retire_t retire_o
);

  // Stalled request keeps its address
  property addr_held_p;
    @(posedge clk_i) disable iff (reset_i)
      (inst_valid_o && !inst_ready_i) |=> $stable(inst_addr_o);
  endproperty

  property retire_after_accept_p;
    @(posedge clk_i) disable iff (reset_i)
      retire_o.valid |-> $past(inst_valid_o && inst_ready_i);
  endproperty

  property addr_aligned_p;
    @(posedge clk_i) disable iff (reset_i)
      inst_valid_o |-> (inst_addr_o[1:0] == 2'b00);
  endproperty

  addr_held_a: assert property (addr_held_p)
    else $error("Fetch address changed while the request was stalled");

  retire_after_accept_a: assert property (retire_after_accept_p)
    else $error("Retire pulse without an accepted fetch in the cycle before");

  addr_aligned_a: assert property (addr_aligned_p)
    else $error("Fetch address is not word aligned");

endmodule

// File: verification/snitch_core_tb.sv
/* Self-checking testbench for the RV32I core.
   Runs a random program from a memory model and checks every retire record
   against an instruction-level reference model. */
`timescale 1ns/1ps

module snitch_core_tb import snitch_pkg::*; ();

  localparam int unsigned NumWords   = 128;
  localparam int unsigned IdxBits    = $clog2(NumWords);
  localparam int unsigned NumRetire  = 800;
  localparam int unsigned CycleLimit = 4 * NumRetire + 100;
  localparam word_t       BootAddr   = 32'h0000_0200;
  // Trap handler sits in the last eight words of the program
  localparam word_t       MtvecAddr  = BootAddr + 4 * (NumWords - 8);
  localparam word_t       Nop        = 32'h0000_0013;

  logic    clk = 1'b0;
  logic    reset;
  word_t   inst_addr, inst_data;
  logic    inst_valid, inst_ready;
  retire_t retire;
  retire_t expected_retire;

  word_t       program_mem [NumWords];
  word_t       model_pc = BootAddr;
  word_t       model_regs [32] = '{default: '0};
  logic [31:0] rng_state = 32'd78;
  logic        boot_checked = 1'b0;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned retired = 0;
  int unsigned cycles = 0;

  snitch_core #(
    .BootAddr     ( BootAddr  ),
    .MtvecAddr    ( MtvecAddr ),
    .RegAddrWidth ( 5         )
  ) snitch_core_i (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .inst_addr_o  ( inst_addr  ),
    .inst_data_i  ( inst_data  ),
    .inst_valid_o ( inst_valid ),
    .inst_ready_i ( inst_ready ),
    .retire_o     ( retire     )
  );

  bind snitch_core snitch_core_sva snitch_core_sva_i (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .inst_addr_o  ( inst_addr_o  ),
    .inst_valid_o ( inst_valid_o ),
    .inst_ready_i ( inst_ready_i ),
    .retire_o     ( retire_o     )
  );

  always #50 clk = ~clk;

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state ^ (rng_state >> 16);
  endfunction

  // Forward only, so every loop passes through the whole program
  function automatic word_t forward_offset(int unsigned idx);
    int unsigned target;
    target = idx + 1 + next_random() % 12;
    if (target > NumWords - 1) begin
      target = NumWords - 1;
    end
    return (target - idx) * 4;
  endfunction

  function automatic word_t random_insn(int unsigned idx, logic allow_ctrl);
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    word_t       off;
    int unsigned kind;
    r    = next_random();
    rd   = r[11:7];
    rs1  = r[19:15];
    rs2  = r[24:20];
    f3   = r[14:12];
    f7   = (r[31] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
    kind = next_random() % 16;
    if (!allow_ctrl) begin
      kind = kind % 11;
    end
    case (kind)
      0, 1, 2, 3, 4: return {f7, rs2, rs1, f3, rd, OpcodeOp};
      5, 6, 7, 8: begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          return {f7, r[24:20], rs1, f3, rd, OpcodeOpImm};
        end
        return {r[31:20], rs1, f3, rd, OpcodeOpImm};
      end
      9:  return {r[31:12], rd, OpcodeLui};
      10: return {r[31:12], rd, OpcodeAuipc};
      11: begin
        off = forward_offset(idx);
        return {off[20], off[10:1], off[11], off[19:12], rd, OpcodeJal};
      end
      12: begin
        // Absolute target from x0, odd now and then
        off = forward_offset(idx) + idx * 4 + BootAddr + {31'b0, r[0]};
        return {off[11:0], 5'd0, 3'b000, rd, OpcodeJalr};
      end
      13, 14: begin
        off = forward_offset(idx);
        if (f3 == 3'b010 || f3 == 3'b011) begin
          f3 = f3 ^ 3'b110;
        end
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpcodeBranch};
      end
      default: return {r[31:7], 7'b0000011};
    endcase
  endfunction

  function automatic word_t fetch_word(word_t addr);
    word_t offset;
    offset = addr - BootAddr;
    if (addr >= BootAddr && offset < 4 * NumWords) begin
      return program_mem[offset[IdxBits+1:2]];
    end
    return Nop;
  endfunction

  task automatic drive_fetch();
    inst_data  = fetch_word(inst_addr);
    inst_ready = ((next_random() % 4) != 0);
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic word_t expected_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $unsigned($signed(a) >>> b[4:0]);
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic retire_t model_step();
    retire_t    r;
    word_t      insn, a, b, imm_i, imm_b, imm_j, res, next;
    logic [4:0] rd;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ill, wr, taken;
    insn  = fetch_word(model_pc);
    rd    = insn[11:7];
    f3    = insn[14:12];
    f7    = insn[31:25];
    a     = model_regs[insn[19:15]];
    b     = model_regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    res   = model_pc + 4;
    next  = model_pc + 4;
    wr    = 1'b1;
    ill   = 1'b0;
    taken = 1'b0;
    case (insn[6:0])
      OpcodeOp: begin
        res = expected_alu(f3, f7[5], a, b);
        ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
      end
      OpcodeOpImm: begin
        res = expected_alu(f3, f3 == 3'b101 && f7[5], a, imm_i);
        ill = (f3 == 3'b001 && f7 != 7'h00) ||
              (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
      end
      OpcodeLui:   res = {insn[31:12], 12'b0};
      OpcodeAuipc: res = model_pc + {insn[31:12], 12'b0};
      OpcodeJal:   next = model_pc + imm_j;
      OpcodeJalr: begin
        next = (a + imm_i) & ~32'd1;
        ill  = (f3 != 3'b000);
      end
      OpcodeBranch: begin
        wr = 1'b0;
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: ill = 1'b1;
        endcase
        if (taken) begin
          next = model_pc + imm_b;
        end
      end
      default: ill = 1'b1;
    endcase
    if (ill) begin
      wr   = 1'b0;
      next = MtvecAddr;
    end
    wr       = wr && (rd != 5'd0);
    r        = '0;
    r.valid  = 1'b1;
    r.trap   = ill;
    r.pc     = model_pc;
    r.insn   = insn;
    if (wr) begin
      r.rd           = rd;
      r.wdata        = res;
      model_regs[rd] = res;
    end
    model_pc = next;
    return r;
  endfunction

  task automatic check_field(string name, word_t expected, word_t actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("ERROR %s at retire %0d: expected %h, actual %h", name, retired, expected,
               actual);
    end
  endtask

  // --------------------------------------------------
  // Program, reset and fetch responses
  // --------------------------------------------------
  initial begin
    word_t back;
    reset      = 1'b1;
    inst_ready = 1'b0;
    inst_data  = Nop;
    // Register setup block, then random code, then a jump back past the setup
    for (int i = 0; i < 32; i++) begin
      program_mem[i[IdxBits-1:0]] = {next_random() & 32'hFFF0_0000} | {20'd0, i[4:0], 7'd0} |
                                    {25'd0, OpcodeOpImm};
    end
    for (int i = 32; i < NumWords - 1; i++) begin
      program_mem[i[IdxBits-1:0]] = random_insn(i, i < NumWords - 8);
    end
    back = 32'd0 - 4 * (NumWords - 33);
    program_mem[NumWords-1] = {back[20], back[10:1], back[11], back[19:12], 5'd0, OpcodeJal};
    repeat (3) @(posedge clk);
    #5;
    reset = 1'b0;
    forever begin
      drive_fetch();
      @(posedge clk);
      #5;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: %0d of %0d instructions retired after %0d cycles", retired, NumRetire,
               cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // Checker
  // --------------------------------------------------
  always @(negedge clk) begin
    if (reset) begin
      checks++;
      assert (!retire.valid && !inst_valid) else begin
        errors++;
        $display("Fetch valid or retire valid was high during reset");
      end
    end else begin
      if (inst_valid && !boot_checked) begin
        check_field("boot address", BootAddr, inst_addr);
        boot_checked = 1'b1;
      end
      if (retire.valid) begin
        expected_retire = model_step();
        check_field("retire pc", expected_retire.pc, retire.pc);
        check_field("retire insn", expected_retire.insn, retire.insn);
        check_field("retire rd", 32'(expected_retire.rd), 32'(retire.rd));
        check_field("retire wdata", expected_retire.wdata, retire.wdata);
        check_field("retire trap", 32'(expected_retire.trap), 32'(retire.trap));
        retired++;
        if (retired == NumRetire) begin
          $display("Retired %0d instructions, %0d checks, %0d errors", retired, checks, errors);
          if (errors == 0) begin
            $display("STATUS: PASS");
          end else begin
            $display("STATUS: FAIL");
          end
          $finish;
        end
      end
    end
  end

endmodule

// File: src.f
logic/snitch_pkg.sv
logic/snitch_fetch.sv
logic/snitch_decoder.sv
logic/snitch_regfile.sv
logic/snitch_execute.sv
logic/snitch_core.sv
verification/snitch_core_sva.sv
verification/snitch_core_tb.sv

// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f src.f --top-module snitch_core_tb -o snitch_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/snitch_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
